//--- design/boot_mem_pkg.sv
package boot_mem_pkg;

	// Bus word used for addresses and data
	localparam int unsigned WORD_BITS = 32;
	typedef logic [WORD_BITS-1:0] word_t;
	typedef logic [3:0] be_t;

	// Address step between copied words
	localparam word_t WORD_BYTES = 32'd4;

	// Address map
	localparam int unsigned SRAM_ADDR_BITS = 17;
	localparam int unsigned DDR_ADDR_BITS = 28;
	localparam logic [3:0] DDR_BASE_NIBBLE = 4'hF;

	// Boot strap encoding
	typedef enum logic [1:0] {
		BOOT_ROM  = 2'd0,
		BOOT_SRAM = 2'd1,
		BOOT_DDR  = 2'd2
	} boot_src_e;

	typedef enum logic {
		DEST_SRAM = 1'b0,
		DEST_DDR  = 1'b1
	} copy_dest_e;

	// Register word index, byte address is index times 4
	typedef enum logic [1:0] {
		REG_CTRL   = 2'd0,
		REG_STATUS = 2'd1,
		REG_START  = 2'd2,
		REG_STOP   = 2'd3
	} reg_idx_e;

	// Control register fields
	localparam int unsigned CTRL_START_BIT = 0;
	localparam int unsigned CTRL_DEST_BIT = 1;

	// Copy configuration seen by the engine and the mux
	typedef struct packed {
		logic       start_copy;
		copy_dest_e dest;
		word_t      start_addr;
		word_t      stop_addr;
	} boot_cfg_t;

	typedef enum logic [2:0] {
		ARB_IDLE,
		WAIT_BOTH,
		WAIT_DATA,
		WAIT_INSTR,
		ARB_ACK
	} arb_state_e;

	typedef enum logic [2:0] {
		COPY_IDLE,
		READ_ROM,
		WRITE_RAM,
		INCR_ADDR,
		END_COPY
	} copy_state_e;

endpackage

//--- design/mem_port_if.sv
`timescale 1ns/10ps

// One memory port with a level handshake
// Request and fields stay steady until ready is seen high
interface mem_port_if import boot_mem_pkg::*; ();

	// Request side
	logic  rd;
	logic  wr;
	word_t addr;
	word_t wdata;
	be_t   be;

	// Response side
	word_t rdata;
	logic  ready;

	modport master (
		output rd, wr, addr, wdata, be,
		input  rdata, ready
	);

	modport slave (
		input  rd, wr, addr, wdata, be,
		output rdata, ready
	);

endinterface

//--- design/boot_regs.sv
`timescale 1ns/10ps

module boot_regs import boot_mem_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_ni,
	input  logic       wb_cyc_i,
	input  logic       wb_stb_i,
	input  logic       wb_we_i,
	input  logic [3:0] wb_adr_i,
	input  word_t      wb_dat_i,
	output word_t      wb_dat_o,
	output logic       wb_ack_o,
	input  logic [1:0] boot_source_i,
	input  logic       copy_done_i,
	input  logic       exec_from_copy_i,
	output boot_cfg_t  cfg_o
);

	reg_idx_e idx;
	logic     req;
	logic     accept;
	logic     ack_q;
	logic     served_q;
	word_t    ctrl_q;
	word_t    start_q;
	word_t    stop_q;
	word_t    status;

	// Word index from the byte address
	assign idx = reg_idx_e'(wb_adr_i[3:2]);
	assign req = wb_cyc_i & wb_stb_i;
	// New cycle only once the previous strobe has been dropped
	assign accept = req & ~ack_q & ~served_q;

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			ack_q <= 1'b0;
			served_q <= 1'b0;
		end else begin
			ack_q <= accept;
			// Remember an acked cycle while the master keeps its strobe up
			served_q <= req & (served_q | ack_q);
		end
	end

	assign wb_ack_o = ack_q & req;

	// Writes land on the edge that raises the ack
	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			ctrl_q <= '0;
			start_q <= '0;
			stop_q <= '0;
		end else begin
			if (accept && wb_we_i) begin
				case (idx)
					REG_CTRL:  ctrl_q <= wb_dat_i;
					REG_START: start_q <= wb_dat_i;
					REG_STOP:  stop_q <= wb_dat_i;
					default: ;
				endcase
			end
			// Hardware clears the start request at the end of a copy
			if (copy_done_i) begin
				ctrl_q[CTRL_START_BIT] <= 1'b0;
			end
		end
	end

	// Status is read only, straps above the executing flag
	assign status = {{(WORD_BITS-3){1'b0}}, boot_source_i, exec_from_copy_i};

	always_comb begin
		case (idx)
			REG_CTRL:   wb_dat_o = ctrl_q;
			REG_STATUS: wb_dat_o = status;
			REG_START:  wb_dat_o = start_q;
			default:    wb_dat_o = stop_q;
		endcase
	end

	assign cfg_o.start_copy = ctrl_q[CTRL_START_BIT];
	assign cfg_o.dest = copy_dest_e'(ctrl_q[CTRL_DEST_BIT]);
	assign cfg_o.start_addr = start_q;
	assign cfg_o.stop_addr = stop_q;

endmodule

//--- design/dual_access_arbiter.sv
`timescale 1ns/10ps

module dual_access_arbiter import boot_mem_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_ni,
	input  logic       cpu_instr_rd_i,
	input  word_t      cpu_instr_addr_i,
	input  logic       cpu_data_rd_i,
	input  logic       cpu_data_wr_i,
	input  word_t      cpu_data_addr_i,
	input  word_t      cpu_data_wdata_i,
	input  be_t        cpu_data_be_i,
	output word_t      cpu_instr_rdata_o,
	output word_t      cpu_data_rdata_o,
	output logic       mem_ready_o,
	output logic       arb_idle_o,
	mem_port_if.master instr_port,
	mem_port_if.master data_port
);

	arb_state_e state_q;
	arb_state_e state_d;
	logic       data_req;
	logic       both_req;
	logic       idle_ready;
	word_t      instr_q;
	word_t      data_q;

	assign data_req = cpu_data_rd_i | cpu_data_wr_i;
	assign both_req = cpu_instr_rd_i & data_req;

	// Completion seen while no concurrent access is tracked
	always_comb begin
		if (both_req) begin
			idle_ready = instr_port.ready & data_port.ready;
		end else if (cpu_instr_rd_i) begin
			idle_ready = instr_port.ready;
		end else if (data_req) begin
			idle_ready = data_port.ready;
		end else begin
			idle_ready = 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			state_q <= ARB_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			ARB_IDLE: begin
				// Only concurrent accesses need tracking
				if (both_req) begin
					if (!instr_port.ready && !data_port.ready) begin
						state_d = WAIT_BOTH;
					end else if (!data_port.ready) begin
						state_d = WAIT_DATA;
					end else if (!instr_port.ready) begin
						state_d = WAIT_INSTR;
					end
				end
			end
			WAIT_BOTH: begin
				if (instr_port.ready && data_port.ready) begin
					state_d = ARB_ACK;
				end else if (instr_port.ready) begin
					state_d = WAIT_DATA;
				end else if (data_port.ready) begin
					state_d = WAIT_INSTR;
				end
			end
			WAIT_DATA: begin
				if (data_port.ready) begin
					state_d = ARB_ACK;
				end
			end
			WAIT_INSTR: begin
				if (instr_port.ready) begin
					state_d = ARB_ACK;
				end
			end
			// Single cycle release of the CPU
			default: state_d = ARB_IDLE;
		endcase
	end

	// Drop a bus request once that side has completed
	assign instr_port.rd = cpu_instr_rd_i & (state_q != WAIT_DATA) & (state_q != ARB_ACK);
	assign instr_port.wr = 1'b0;
	assign instr_port.addr = cpu_instr_addr_i;
	assign instr_port.wdata = '0;
	assign instr_port.be = '0;

	assign data_port.rd = cpu_data_rd_i & (state_q != WAIT_INSTR) & (state_q != ARB_ACK);
	assign data_port.wr = cpu_data_wr_i & (state_q != WAIT_INSTR) & (state_q != ARB_ACK);
	assign data_port.addr = cpu_data_addr_i;
	assign data_port.wdata = cpu_data_wdata_i;
	assign data_port.be = cpu_data_be_i;

	// Hold read data of whichever side finishes first
	always_ff @(posedge clk_i) begin
		if (instr_port.rd && instr_port.ready) begin
			instr_q <= instr_port.rdata;
		end
		if (data_port.rd && data_port.ready) begin
			data_q <= data_port.rdata;
		end
	end

	// Captured words in ARB_ACK, bus words otherwise
	assign cpu_instr_rdata_o = (state_q == ARB_ACK) ? instr_q : instr_port.rdata;
	assign cpu_data_rdata_o = (state_q == ARB_ACK) ? data_q : data_port.rdata;

	assign mem_ready_o = (state_q == ARB_ACK) | ((state_q == ARB_IDLE) & idle_ready);

	// Access boundary where a copy may take over the buses
	assign arb_idle_o = (state_q == ARB_IDLE) & (idle_ready | ~(cpu_instr_rd_i | data_req));

endmodule

//--- design/code_copy_engine.sv
`timescale 1ns/10ps

module code_copy_engine import boot_mem_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_ni,
	input  boot_cfg_t  cfg_i,
	input  logic       arb_idle_i,
	output logic       copy_busy_o,
	output logic       copy_done_o,
	output logic       exec_from_copy_o,
	mem_port_if.master copy_rd_port,
	mem_port_if.master copy_wr_port
);

	copy_state_e state_q;
	copy_state_e state_d;
	word_t       addr_q;
	word_t       hold_q;
	logic        exec_q;
	logic        last_word;

	// Stop address is inclusive
	assign last_word = (addr_q == cfg_i.stop_addr);

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			state_q <= COPY_IDLE;
			addr_q <= '0;
			exec_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == COPY_IDLE && state_d == READ_ROM) begin
				addr_q <= cfg_i.start_addr;
			end else if (state_q == INCR_ADDR && !last_word) begin
				addr_q <= addr_q + WORD_BYTES;
			end
			// Sticky until reset
			if (copy_done_o) begin
				exec_q <= 1'b1;
			end
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			COPY_IDLE: begin
				// Wait for the CPU to reach an access boundary
				if (cfg_i.start_copy && arb_idle_i) begin
					state_d = READ_ROM;
				end
			end
			READ_ROM: begin
				if (copy_rd_port.ready) begin
					state_d = WRITE_RAM;
				end
			end
			WRITE_RAM: begin
				if (copy_wr_port.ready) begin
					state_d = INCR_ADDR;
				end
			end
			INCR_ADDR: begin
				state_d = last_word ? END_COPY : READ_ROM;
			end
			// One drain cycle before the buses go back to the CPU
			default: state_d = COPY_IDLE;
		endcase
	end

	// ROM word lands here between read and write
	always_ff @(posedge clk_i) begin
		if (state_q == READ_ROM && copy_rd_port.ready) begin
			hold_q <= copy_rd_port.rdata;
		end
	end

	assign copy_done_o = (state_q == INCR_ADDR) & last_word;
	assign copy_busy_o = (state_q != COPY_IDLE);
	assign exec_from_copy_o = exec_q;

	assign copy_rd_port.rd = (state_q == READ_ROM);
	assign copy_rd_port.wr = 1'b0;
	assign copy_rd_port.addr = addr_q;
	assign copy_rd_port.wdata = '0;
	assign copy_rd_port.be = '0;

	// Whole word writes, the mux maps the address
	assign copy_wr_port.rd = 1'b0;
	assign copy_wr_port.wr = (state_q == WRITE_RAM);
	assign copy_wr_port.addr = addr_q;
	assign copy_wr_port.wdata = hold_q;
	assign copy_wr_port.be = '1;

endmodule

//--- design/mem_bus_mux.sv
`timescale 1ns/10ps

module mem_bus_mux import boot_mem_pkg::*; (
	input  logic [1:0] boot_source_i,
	input  boot_cfg_t  cfg_i,
	input  logic       copy_busy_i,
	input  logic       exec_from_copy_i,
	output logic       instr_rd_o,
	output word_t      instr_addr_o,
	input  word_t      instr_rdata_i,
	input  logic       instr_ready_i,
	output logic       data_rd_o,
	output logic       data_wr_o,
	output word_t      data_addr_o,
	output word_t      data_wdata_o,
	output be_t        data_be_o,
	input  word_t      data_rdata_i,
	input  logic       data_ready_i,
	mem_port_if.slave  instr_port,
	mem_port_if.slave  data_port,
	mem_port_if.slave  copy_rd_port,
	mem_port_if.slave  copy_wr_port
);

	word_t fetch_addr;
	word_t copy_dest_addr;

	// Low SRAM window, upper bits cleared
	function automatic word_t map_sram(input word_t addr);
		return {{(WORD_BITS-SRAM_ADDR_BITS){1'b0}}, addr[SRAM_ADDR_BITS-1:0]};
	endfunction

	// DDR window at the top nibble
	function automatic word_t map_ddr(input word_t addr);
		return {DDR_BASE_NIBBLE, addr[DDR_ADDR_BITS-1:0]};
	endfunction

	function automatic word_t map_dest(input word_t addr, input copy_dest_e dest);
		return (dest == DEST_DDR) ? map_ddr(addr) : map_sram(addr);
	endfunction

	// Fetch space from the straps until code runs from the copy
	always_comb begin
		if (exec_from_copy_i) begin
			fetch_addr = map_dest(instr_port.addr, cfg_i.dest);
		end else begin
			case (boot_src_e'(boot_source_i))
				BOOT_SRAM: fetch_addr = map_sram(instr_port.addr);
				BOOT_DDR:  fetch_addr = map_ddr(instr_port.addr);
				default:   fetch_addr = instr_port.addr;
			endcase
		end
	end

	assign copy_dest_addr = map_dest(copy_wr_port.addr, cfg_i.dest);

	// Copy owns both buses while busy
	always_comb begin
		if (copy_busy_i) begin
			instr_rd_o = copy_rd_port.rd;
			instr_addr_o = copy_rd_port.addr;
			data_rd_o = copy_wr_port.rd;
			data_wr_o = copy_wr_port.wr;
			data_addr_o = copy_dest_addr;
			data_wdata_o = copy_wr_port.wdata;
			data_be_o = copy_wr_port.be;
		end else begin
			instr_rd_o = instr_port.rd;
			instr_addr_o = fetch_addr;
			data_rd_o = data_port.rd;
			data_wr_o = data_port.wr;
			// CPU data addresses are not remapped
			data_addr_o = data_port.addr;
			data_wdata_o = data_port.wdata;
			data_be_o = data_port.be;
		end
	end

	// CPU ports see no ready during a copy
	assign instr_port.ready = instr_ready_i & ~copy_busy_i;
	assign data_port.ready = data_ready_i & ~copy_busy_i;
	assign copy_rd_port.ready = instr_ready_i & copy_busy_i;
	assign copy_wr_port.ready = data_ready_i & copy_busy_i;

	assign instr_port.rdata = instr_rdata_i;
	assign copy_rd_port.rdata = instr_rdata_i;
	assign data_port.rdata = data_rdata_i;
	assign copy_wr_port.rdata = data_rdata_i;

endmodule

//--- design/boot_mem_ctrl.sv
`timescale 1ns/10ps

module boot_mem_ctrl import boot_mem_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_ni,
	input  logic [1:0] boot_source_i,
	// Register port
	input  logic       wb_cyc_i,
	input  logic       wb_stb_i,
	input  logic       wb_we_i,
	input  logic [3:0] wb_adr_i,
	input  word_t      wb_dat_i,
	output word_t      wb_dat_o,
	output logic       wb_ack_o,
	// CPU side
	input  logic       cpu_instr_rd_i,
	input  word_t      cpu_instr_addr_i,
	output word_t      cpu_instr_rdata_o,
	input  logic       cpu_data_rd_i,
	input  logic       cpu_data_wr_i,
	input  word_t      cpu_data_addr_i,
	input  word_t      cpu_data_wdata_i,
	input  be_t        cpu_data_be_i,
	output word_t      cpu_data_rdata_o,
	output logic       mem_ready_o,
	// Instruction bus
	output logic       instr_rd_o,
	output word_t      instr_addr_o,
	input  word_t      instr_rdata_i,
	input  logic       instr_ready_i,
	// Data bus
	output logic       data_rd_o,
	output logic       data_wr_o,
	output word_t      data_addr_o,
	output word_t      data_wdata_o,
	output be_t        data_be_o,
	input  word_t      data_rdata_i,
	input  logic       data_ready_i
);

	boot_cfg_t cfg;
	logic      copy_done;
	logic      exec_from_copy;
	logic      copy_busy;
	logic      arb_idle;

	mem_port_if instr_port ();
	mem_port_if data_port ();
	mem_port_if copy_rd_port ();
	mem_port_if copy_wr_port ();

	boot_regs u_regs (
		.clk_i            (clk_i),
		.rst_ni           (rst_ni),
		.wb_cyc_i         (wb_cyc_i),
		.wb_stb_i         (wb_stb_i),
		.wb_we_i          (wb_we_i),
		.wb_adr_i         (wb_adr_i),
		.wb_dat_i         (wb_dat_i),
		.wb_dat_o         (wb_dat_o),
		.wb_ack_o         (wb_ack_o),
		.boot_source_i    (boot_source_i),
		.copy_done_i      (copy_done),
		.exec_from_copy_i (exec_from_copy),
		.cfg_o            (cfg)
	);

	dual_access_arbiter u_arb (
		.clk_i             (clk_i),
		.rst_ni            (rst_ni),
		.cpu_instr_rd_i    (cpu_instr_rd_i),
		.cpu_instr_addr_i  (cpu_instr_addr_i),
		.cpu_data_rd_i     (cpu_data_rd_i),
		.cpu_data_wr_i     (cpu_data_wr_i),
		.cpu_data_addr_i   (cpu_data_addr_i),
		.cpu_data_wdata_i  (cpu_data_wdata_i),
		.cpu_data_be_i     (cpu_data_be_i),
		.cpu_instr_rdata_o (cpu_instr_rdata_o),
		.cpu_data_rdata_o  (cpu_data_rdata_o),
		.mem_ready_o       (mem_ready_o),
		.arb_idle_o        (arb_idle),
		.instr_port        (instr_port.master),
		.data_port         (data_port.master)
	);

	code_copy_engine u_copy (
		.clk_i            (clk_i),
		.rst_ni           (rst_ni),
		.cfg_i            (cfg),
		.arb_idle_i       (arb_idle),
		.copy_busy_o      (copy_busy),
		.copy_done_o      (copy_done),
		.exec_from_copy_o (exec_from_copy),
		.copy_rd_port     (copy_rd_port.master),
		.copy_wr_port     (copy_wr_port.master)
	);

	mem_bus_mux u_mux (
		.boot_source_i    (boot_source_i),
		.cfg_i            (cfg),
		.copy_busy_i      (copy_busy),
		.exec_from_copy_i (exec_from_copy),
		.instr_rd_o       (instr_rd_o),
		.instr_addr_o     (instr_addr_o),
		.instr_rdata_i    (instr_rdata_i),
		.instr_ready_i    (instr_ready_i),
		.data_rd_o        (data_rd_o),
		.data_wr_o        (data_wr_o),
		.data_addr_o      (data_addr_o),
		.data_wdata_o     (data_wdata_o),
		.data_be_o        (data_be_o),
		.data_rdata_i     (data_rdata_i),
		.data_ready_i     (data_ready_i),
		.instr_port       (instr_port.slave),
		.data_port        (data_port.slave),
		.copy_rd_port     (copy_rd_port.slave),
		.copy_wr_port     (copy_wr_port.slave)
	);

endmodule

//--- testbench/boot_mem_ctrl_assertions.sv
`timescale 1ns/10ps

module boot_mem_ctrl_assertions import boot_mem_pkg::*; (
	input logic       clk_i,
	input logic       rst_ni,
	input logic       wb_cyc_i,
	input logic       wb_stb_i,
	input logic       wb_ack_o,
	input logic       mem_ready_o,
	input logic       copy_busy_i,
	input arb_state_e arb_state_i
);

	// Ack only inside an active Wishbone cycle, one cycle after an unacked strobe
	ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
		wb_ack_o |-> (wb_cyc_i && wb_stb_i && $past(wb_cyc_i && wb_stb_i && !wb_ack_o)))
		else $error("wb_ack_o high without a pending wb_cyc_i and wb_stb_i");

	// CPU is held while the copy owns the buses
	no_ready_in_copy: assert property (@(posedge clk_i) disable iff (!rst_ni)
		copy_busy_i |-> !mem_ready_o)
		else $error("mem_ready_o high during a copy");

	// Release state lasts a single cycle
	ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(arb_state_i == ARB_ACK) |=> (arb_state_i != ARB_ACK))
		else $error("arbiter stayed in ARB_ACK for more than one cycle");

endmodule

bind boot_mem_ctrl boot_mem_ctrl_assertions u_assertions (
	.clk_i       (clk_i),
	.rst_ni      (rst_ni),
	.wb_cyc_i    (wb_cyc_i),
	.wb_stb_i    (wb_stb_i),
	.wb_ack_o    (wb_ack_o),
	.mem_ready_o (mem_ready_o),
	.copy_busy_i (copy_busy),
	.arb_state_i (u_arb.state_q)
);

//--- testbench/tb_boot_mem_ctrl.sv
`timescale 1ns/10ps

module tb_boot_mem_ctrl import boot_mem_pkg::*; ();

	localparam int NUM_REG_ROUNDS = 8;
	localparam int NUM_FETCH = 16;
	localparam int NUM_CONC = 40;
	localparam int MAX_WORDS = 6;
	localparam int MAX_WAIT = 120;
	localparam int WORST_CYCLES = 12;
	localparam int NUM_OPS = NUM_REG_ROUNDS * 6 + NUM_FETCH + NUM_CONC + 2 * (MAX_WORDS * 3 + 12);
	localparam int TIMEOUT_NS = (NUM_OPS * WORST_CYCLES + 300) * 10;

	logic       clk_i;
	logic       rst_ni;
	logic [1:0] boot_source_i;
	logic       wb_cyc_i;
	logic       wb_stb_i;
	logic       wb_we_i;
	logic [3:0] wb_adr_i;
	word_t      wb_dat_i;
	word_t      wb_dat_o;
	logic       wb_ack_o;
	logic       cpu_instr_rd_i;
	word_t      cpu_instr_addr_i;
	word_t      cpu_instr_rdata_o;
	logic       cpu_data_rd_i;
	logic       cpu_data_wr_i;
	word_t      cpu_data_addr_i;
	word_t      cpu_data_wdata_i;
	be_t        cpu_data_be_i;
	word_t      cpu_data_rdata_o;
	logic       mem_ready_o;
	logic       instr_rd_o;
	word_t      instr_addr_o;
	word_t      instr_rdata_i;
	logic       instr_ready_i;
	logic       data_rd_o;
	logic       data_wr_o;
	word_t      data_addr_o;
	word_t      data_wdata_o;
	be_t        data_be_o;
	word_t      data_rdata_i;
	logic       data_ready_i;

	integer seed = 32'hfd8;

	// Bus model state
	word_t data_mem [word_t];
	word_t ref_mem [word_t];
	word_t last_instr_addr;
	int    i_wait;
	int    d_wait;
	logic  i_busy;
	logic  d_busy;

	// Expected controller state
	logic       exp_exec;
	copy_dest_e exp_dest;

	boot_mem_ctrl u_dut (.*);

	always #5 clk_i = ~clk_i;

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish in the expected time");
		$display("Checks failed");
		$fatal(1);
	end

	// Contents of any location never written, built from the whole address
	function automatic word_t fill_word(input word_t a);
		return (a * 32'h9e37_79b9) ^ {a[7:0], a[31:8]};
	endfunction

	function automatic word_t merge_bytes(input word_t old, input word_t nw, input be_t be);
		word_t r;
		r = old;
		for (int b = 0; b < 4; b++) begin
			if (be[b]) r[b*8 +: 8] = nw[b*8 +: 8];
		end
		return r;
	endfunction

	// Map rules of the address decoder
	function automatic word_t to_sram(input word_t a);
		return a & 32'h0001_ffff;
	endfunction

	function automatic word_t to_ddr(input word_t a);
		return {4'hf, a[27:0]};
	endfunction

	function automatic word_t expected_fetch_addr(input word_t a);
		if (exp_exec) return (exp_dest == DEST_DDR) ? to_ddr(a) : to_sram(a);
		if (boot_source_i == BOOT_SRAM) return to_sram(a);
		if (boot_source_i == BOOT_DDR) return to_ddr(a);
		return a;
	endfunction

	function automatic word_t ref_read(input word_t a);
		return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
	endfunction

	task automatic check_equal(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1);
	endtask

	// Instruction bus model, ready after 0 to 3 cycles
	always @(negedge clk_i) begin
		if (!rst_ni || !instr_rd_o) begin
			instr_ready_i <= 1'b0;
			i_busy = 1'b0;
		end else begin
			if (!i_busy) begin
				i_busy = 1'b1;
				i_wait = $unsigned($random(seed)) % 4;
			end
			if (i_wait == 0) begin
				instr_ready_i <= 1'b1;
				instr_rdata_i <= fill_word(instr_addr_o);
				last_instr_addr = instr_addr_o;
				i_busy = 1'b0;
			end else begin
				i_wait--;
				instr_ready_i <= 1'b0;
			end
		end
	end

	// Data bus model with byte enables
	always @(negedge clk_i) begin
		if (!rst_ni || !(data_rd_o || data_wr_o)) begin
			data_ready_i <= 1'b0;
			d_busy = 1'b0;
		end else begin
			if (!d_busy) begin
				d_busy = 1'b1;
				d_wait = $unsigned($random(seed)) % 4;
			end
			if (d_wait == 0) begin
				data_ready_i <= 1'b1;
				if (data_wr_o) begin
					data_mem[data_addr_o] = merge_bytes(data_mem.exists(data_addr_o) ?
						data_mem[data_addr_o] : fill_word(data_addr_o), data_wdata_o, data_be_o);
				end else begin
					data_rdata_i <= data_mem.exists(data_addr_o) ?
						data_mem[data_addr_o] : fill_word(data_addr_o);
				end
				d_busy = 1'b0;
			end else begin
				d_wait--;
				data_ready_i <= 1'b0;
			end
		end
	end

	task automatic apply_reset();
		rst_ni = 1'b0;
		exp_exec = 1'b0;
		repeat (2) @(posedge clk_i);
		#1 rst_ni = 1'b1;
	endtask

	task automatic wb_access(input logic we, input reg_idx_e idx, input word_t wdat,
			output word_t rdat);
		int n;
		n = 0;
		@(posedge clk_i);
		#1;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i = we;
		wb_adr_i = {idx, 2'b00};
		wb_dat_i = wdat;
		@(negedge clk_i);
		#1;
		while (!wb_ack_o) begin
			n++;
			if (n > MAX_WAIT) report_failure("Wishbone ack never arrived");
			@(negedge clk_i);
			#1;
		end
		check_equal("wb_ack_o latency", n, 1);
		rdat = wb_dat_o;
		@(posedge clk_i);
		#1;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
	endtask

	task automatic reg_write(input reg_idx_e idx, input word_t v);
		word_t dummy;
		wb_access(1'b1, idx, v, dummy);
	endtask

	task automatic reg_read_check(input reg_idx_e idx, input word_t exp, input string name);
		word_t v;
		wb_access(1'b0, idx, '0, v);
		check_equal(name, v, exp);
	endtask

	// One CPU access, fetch and data may be concurrent
	task automatic cpu_access(input logic fetch, input logic drd, input logic dwr,
			input word_t iaddr, input word_t daddr, input word_t wdata, input be_t be);
		word_t exp_instr;
		word_t exp_data;
		int    n;
		n = 0;
		exp_data = ref_read(daddr);
		if (dwr) ref_mem[daddr] = merge_bytes(exp_data, wdata, be);
		@(posedge clk_i);
		#1;
		cpu_instr_rd_i = fetch;
		cpu_instr_addr_i = iaddr;
		cpu_data_rd_i = drd;
		cpu_data_wr_i = dwr;
		cpu_data_addr_i = daddr;
		cpu_data_wdata_i = wdata;
		cpu_data_be_i = be;
		@(negedge clk_i);
		#1;
		while (!mem_ready_o) begin
			n++;
			if (n > MAX_WAIT) report_failure("CPU access never completed");
			@(negedge clk_i);
			#1;
		end
		// Mapping depends on the state when the access completes
		exp_instr = fill_word(expected_fetch_addr(iaddr));
		if (fetch) begin
			check_equal("instr_addr_o", last_instr_addr, expected_fetch_addr(iaddr));
			check_equal("cpu_instr_rdata_o", cpu_instr_rdata_o, exp_instr);
		end
		if (drd) check_equal("cpu_data_rdata_o", cpu_data_rdata_o, exp_data);
		@(posedge clk_i);
		#1;
		cpu_instr_rd_i = 1'b0;
		cpu_data_rd_i = 1'b0;
		cpu_data_wr_i = 1'b0;
		@(negedge clk_i);
		#1;
		check_equal("mem_ready_o after access", mem_ready_o, 1'b0);
		if (dwr) check_equal("data_mem", data_mem[daddr], ref_mem[daddr]);
	endtask

	task automatic copy_run(input copy_dest_e dest);
		word_t start;
		word_t a;
		int    words;
		@(posedge clk_i);
		#1;
		apply_reset();
		boot_source_i = BOOT_DDR;
		reg_read_check(REG_STATUS, {29'd0, 2'(BOOT_DDR), 1'b0}, "status before copy");
		words = 2 + $unsigned($random(seed)) % (MAX_WORDS - 1);
		start = 32'h0002_0000 | {20'd0, 12'($random(seed)) & 12'h3fc};
		reg_write(REG_START, start);
		reg_write(REG_STOP, start + (words - 1) * 4);
		exp_dest = dest;
		reg_write(REG_CTRL, {30'd0, dest, 1'b1});
		// Fetch issued while the copy runs, mapped once it ends
		exp_exec = 1'b1;
		cpu_access(1'b1, 1'b0, 1'b0, start, '0, '0, '0);
		reg_read_check(REG_CTRL, {30'd0, dest, 1'b0}, "ctrl after copy");
		reg_read_check(REG_STATUS, {29'd0, 2'(BOOT_DDR), 1'b1}, "status after copy");
		for (int w = 0; w < words; w++) begin
			a = start + w * 4;
			a = (dest == DEST_DDR) ? to_ddr(a) : to_sram(a);
			ref_mem[a] = fill_word(start + w * 4);
			if (!data_mem.exists(a)) report_failure("Copy did not write a destination word");
			check_equal("copied word", data_mem[a], ref_mem[a]);
		end
		for (int k = 0; k < 4; k++) begin
			cpu_access(1'b1, 1'b0, 1'b0, $random(seed) & 32'hffff_fffc, '0, '0, '0);
		end
	endtask

	initial begin
		word_t v;
		logic  drd;
		clk_i = 1'b0;
		rst_ni = 1'b0;
		boot_source_i = BOOT_ROM;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		cpu_instr_rd_i = 1'b0;
		cpu_instr_addr_i = '0;
		cpu_data_rd_i = 1'b0;
		cpu_data_wr_i = 1'b0;
		cpu_data_addr_i = '0;
		cpu_data_wdata_i = '0;
		cpu_data_be_i = '0;
		instr_rdata_i = '0;
		instr_ready_i = 1'b0;
		data_rdata_i = '0;
		data_ready_i = 1'b0;
		exp_dest = DEST_SRAM;
		apply_reset();

		// Register readback, start bit kept clear so no copy begins
		for (int r = 0; r < NUM_REG_ROUNDS; r++) begin
			v = $random(seed) & 32'hffff_fffe;
			reg_write(REG_CTRL, v);
			reg_read_check(REG_CTRL, v, "ctrl register");
			v = $random(seed);
			reg_write(REG_START, v);
			reg_read_check(REG_START, v, "start register");
			v = $random(seed);
			reg_write(REG_STOP, v);
			reg_read_check(REG_STOP, v, "stop register");
		end
		for (int s = 0; s < 3; s++) begin
			boot_source_i = s[1:0];
			reg_read_check(REG_STATUS, {29'd0, s[1:0], 1'b0}, "status register");
		end

		// Single fetches, strap decoding of ROM, SRAM and DDR spaces
		for (int f = 0; f < NUM_FETCH; f++) begin
			boot_source_i = 2'(f % 3);
			cpu_access(1'b1, 1'b0, 1'b0, $random(seed) & 32'hffff_fffc, '0, '0, '0);
		end

		// Concurrent and single data accesses on a small window
		boot_source_i = BOOT_ROM;
		for (int c = 0; c < NUM_CONC; c++) begin
			drd = $random(seed) & 1;
			cpu_access(c % 4 != 3, drd, ~drd, $random(seed) & 32'hffff_fffc,
				32'h1000_0000 | {22'd0, 8'($random(seed)), 2'b00},
				$random(seed), be_t'($random(seed)));
		end

		copy_run(DEST_SRAM);
		copy_run(DEST_DDR);

		$display("All checks passed");
		$finish;
	end

endmodule

//--- boot_mem_ctrl.f
design/boot_mem_pkg.sv
design/mem_port_if.sv
design/boot_regs.sv
design/dual_access_arbiter.sv
design/code_copy_engine.sv
design/mem_bus_mux.sv
design/boot_mem_ctrl.sv
testbench/boot_mem_ctrl_assertions.sv
testbench/tb_boot_mem_ctrl.sv

//--- Makefile
TOP = tb_boot_mem_ctrl

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -Wno-fatal --top-module $(TOP) -f boot_mem_ctrl.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f boot_mem_ctrl.f -o sim_tb
	out=$$(./obj_dir/sim_tb); echo "$$out"; \
		echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
